//--- design/spi_gpu_pkg.sv
package spi_gpu_pkg;

    typedef logic [3:0]  nibble_t;      // one sample of the four data lanes
    typedef logic [7:0]  byte_t;
    typedef logic [16:0] pixel_addr_t;  // index into the 320x240 framebuffer
    typedef logic [15:0] response_t;

    // bit 7 marks a receive phase, bit 6 a transmit phase
    typedef enum logic [7:0] {
        cmd_fb_write       = 8'h82,
        cmd_read_status    = 8'h40,
        cmd_read_magic     = 8'h60,
        cmd_disable_output = 8'h00,
        cmd_enable_output  = 8'h01
    } command_t;

    typedef enum logic [2:0] {
        st_idle,
        st_command,
        st_receive,
        st_write_dummy,
        st_transmit,
        st_done
    } seq_state_t;

    typedef enum logic {
        resp_status,
        resp_magic
    } response_sel_t;

    localparam int          fb_pixels      = 76800;   // 320 x 240
    localparam int          addr_nibbles   = 6;
    localparam int          dummy_cycles   = 2;
    localparam response_t   magic_number   = 16'hA5C3;
    localparam logic [4:0]  status_pattern = 5'b10110;
    localparam int          status_nibbles = 2;
    localparam int          magic_nibbles  = 4;

endpackage

//--- design/qspi_rx_if.sv
`timescale 1ns/100ps

interface qspi_rx_if;
    logic                 active;         // chip select low, registered
    logic                 start;          // first selected cycle
    spi_gpu_pkg::nibble_t nibble;
    logic                 nibble_strobe;
    logic                 byte_strobe;    // nibble is the low half of a byte

    modport source (output active, start, nibble, nibble_strobe, byte_strobe);

    modport sequencer (input active, start, nibble, nibble_strobe, byte_strobe);

    modport writer (input nibble, nibble_strobe, byte_strobe);

endinterface

//--- design/qspi_frontend.sv
`timescale 1ns/100ps

module qspi_frontend (
    input  logic                 sclk,
    input  logic                 rst_n,
    input  logic                 cs,
    input  spi_gpu_pkg::nibble_t qspi_in,
    qspi_rx_if.source            rx
);

    logic have_high;   // a high nibble is held, the next one completes the byte

    always_ff @(posedge sclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx.active        <= 1'b0;
            rx.start         <= 1'b0;
            rx.nibble_strobe <= 1'b0;
            rx.byte_strobe   <= 1'b0;
            have_high        <= 1'b0;
        end
        else
        begin
            rx.active        <= ~cs;
            rx.nibble_strobe <= ~cs;              // one nibble per selected cycle
            rx.start         <= ~cs & ~rx.active;

            if (cs)
            begin
                rx.byte_strobe <= 1'b0;
                have_high      <= 1'b0;
            end
            else if (!rx.active)
            begin
                // first nibble of a transaction is always a high half
                rx.byte_strobe <= 1'b0;
                have_high      <= 1'b1;
            end
            else
            begin
                rx.byte_strobe <= have_high;
                have_high      <= ~have_high;
            end
        end
    end

    always_ff @(posedge sclk)
    begin
        rx.nibble <= qspi_in;
    end

endmodule

//--- design/command_sequencer.sv
`timescale 1ns/100ps

module command_sequencer (
    input  logic                       sclk,
    input  logic                       rst_n,
    qspi_rx_if.sequencer               rx,
    output logic                       addr_phase,
    output logic                       pixel_phase,
    output logic                       resp_load,
    output logic                       tx_phase,
    output spi_gpu_pkg::response_sel_t resp_sel,
    output logic                       output_enabled
);

    spi_gpu_pkg::seq_state_t state, next_state;
    spi_gpu_pkg::nibble_t    cmd_hi;     // high half of the command byte
    spi_gpu_pkg::byte_t      cmd_next;
    logic [2:0]              phase_cnt;
    logic [2:0]              tx_len;
    logic                    addr_done;
    logic                    count_en;

    assign cmd_next = {cmd_hi, rx.nibble};

    function automatic logic cmd_defined(spi_gpu_pkg::byte_t code);
        case (code)
            spi_gpu_pkg::cmd_fb_write,
            spi_gpu_pkg::cmd_read_status,
            spi_gpu_pkg::cmd_read_magic,
            spi_gpu_pkg::cmd_disable_output,
            spi_gpu_pkg::cmd_enable_output: return 1'b1;
            default:                        return 1'b0;
        endcase
    endfunction

    assign addr_done   = (phase_cnt == 3'(spi_gpu_pkg::addr_nibbles));
    assign addr_phase  = (state == spi_gpu_pkg::st_receive) && !addr_done;
    assign pixel_phase = (state == spi_gpu_pkg::st_receive) && addr_done;
    assign tx_phase    = (state == spi_gpu_pkg::st_transmit) && rx.nibble_strobe;
    assign resp_load   = (state == spi_gpu_pkg::st_write_dummy) && rx.nibble_strobe &&
                         (phase_cnt == 3'(spi_gpu_pkg::dummy_cycles - 1));

    assign tx_len = (resp_sel == spi_gpu_pkg::resp_magic) ? 3'(spi_gpu_pkg::magic_nibbles)
                                                           : 3'(spi_gpu_pkg::status_nibbles);

    // address counter stops at the pixel stream, which runs until chip select rises
    assign count_en = ((state == spi_gpu_pkg::st_receive) && !addr_done) ||
                      (state == spi_gpu_pkg::st_write_dummy) ||
                      (state == spi_gpu_pkg::st_transmit);

    always_comb
    begin
        next_state = state;
        case (state)
            spi_gpu_pkg::st_command:
                if (rx.byte_strobe)
                begin
                    if (cmd_defined(cmd_next) && cmd_next[7])
                        next_state = spi_gpu_pkg::st_receive;
                    else if (cmd_defined(cmd_next) && cmd_next[6])
                        next_state = spi_gpu_pkg::st_write_dummy;
                    else
                        next_state = spi_gpu_pkg::st_done;   // also catches unknown codes
                end
            spi_gpu_pkg::st_write_dummy:
                if (resp_load)
                    next_state = spi_gpu_pkg::st_transmit;
            spi_gpu_pkg::st_transmit:
                if (tx_phase && phase_cnt == tx_len - 3'd1)
                    next_state = spi_gpu_pkg::st_done;
            default: ;
        endcase

        if (rx.start)
            next_state = spi_gpu_pkg::st_command;
        else if (!rx.active)
            next_state = spi_gpu_pkg::st_idle;    // deselect aborts anything in flight
    end

    always_ff @(posedge sclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state          <= spi_gpu_pkg::st_idle;
            phase_cnt      <= '0;
            cmd_hi         <= '0;
            resp_sel       <= spi_gpu_pkg::resp_status;
            output_enabled <= 1'b0;
        end
        else
        begin
            state <= next_state;

            if (next_state != state)
                phase_cnt <= '0;
            else if (rx.nibble_strobe && count_en)
                phase_cnt <= phase_cnt + 3'd1;

            if (rx.start)
                cmd_hi <= rx.nibble;

            if (state == spi_gpu_pkg::st_command && next_state == spi_gpu_pkg::st_write_dummy)
                resp_sel <= (cmd_next == spi_gpu_pkg::cmd_read_magic) ? spi_gpu_pkg::resp_magic
                                                                       : spi_gpu_pkg::resp_status;

            // flag survives chip select, only rst_n clears it
            if (state == spi_gpu_pkg::st_command && next_state == spi_gpu_pkg::st_done)
            begin
                if (cmd_next == spi_gpu_pkg::cmd_enable_output)
                    output_enabled <= 1'b1;
                else if (cmd_next == spi_gpu_pkg::cmd_disable_output)
                    output_enabled <= 1'b0;
            end
        end
    end

endmodule

//--- design/pixel_writer.sv
`timescale 1ns/100ps

module pixel_writer (
    input  logic                     sclk,
    input  logic                     rst_n,
    qspi_rx_if.writer                rx,
    input  logic                     addr_phase,
    input  logic                     pixel_phase,
    output spi_gpu_pkg::pixel_addr_t fb_addr,
    output spi_gpu_pkg::byte_t       fb_data,
    output logic                     fb_wren
);

    spi_gpu_pkg::pixel_addr_t addr_q;     // address of the next pixel byte
    spi_gpu_pkg::pixel_addr_t addr_inc;
    spi_gpu_pkg::nibble_t     pixel_hi;
    logic                     pixel_done;

    assign pixel_done = pixel_phase && rx.byte_strobe;

    // wrap after the last pixel of the frame
    assign addr_inc = (addr_q == spi_gpu_pkg::pixel_addr_t'(spi_gpu_pkg::fb_pixels - 1))
                      ? '0
                      : addr_q + spi_gpu_pkg::pixel_addr_t'(1);

    always_ff @(posedge sclk)
    begin
        // six nibbles arrive, only the low 17 bits survive the shift
        if (addr_phase && rx.nibble_strobe)
            addr_q <= {addr_q[12:0], rx.nibble};
        else if (pixel_done)
            addr_q <= addr_inc;

        if (pixel_phase && rx.nibble_strobe && !rx.byte_strobe)
            pixel_hi <= rx.nibble;

        if (pixel_done)
        begin
            fb_addr <= addr_q;
            fb_data <= {pixel_hi, rx.nibble};
        end
    end

    always_ff @(posedge sclk or negedge rst_n)
    begin
        if (!rst_n)
            fb_wren <= 1'b0;
        else
            fb_wren <= pixel_done;   // one-cycle write strobe
    end

endmodule

//--- design/response_shifter.sv
`timescale 1ns/100ps

module response_shifter (
    input  logic                       sclk,
    input  logic                       rst_n,
    input  logic                       hblank,
    input  logic                       vblank,
    input  logic                       resp_load,
    input  logic                       tx_phase,
    input  spi_gpu_pkg::response_sel_t resp_sel,
    input  logic                       output_enabled,
    output spi_gpu_pkg::nibble_t       qspi_out,
    output logic                       qspi_oe
);

    logic [1:0]             hblank_sync;   // [1] is the synchronized level
    logic [1:0]             vblank_sync;
    spi_gpu_pkg::byte_t     status_byte;
    spi_gpu_pkg::response_t shift_q;

    assign status_byte = {spi_gpu_pkg::status_pattern, hblank_sync[1], vblank_sync[1],
                          output_enabled};

    // blank signals come from the video clock domain
    always_ff @(posedge sclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hblank_sync <= '0;
            vblank_sync <= '0;
        end
        else
        begin
            hblank_sync <= {hblank_sync[0], hblank};
            vblank_sync <= {vblank_sync[0], vblank};
        end
    end

    always_ff @(posedge sclk)
    begin
        if (resp_load)
        begin
            if (resp_sel == spi_gpu_pkg::resp_magic)
                shift_q <= spi_gpu_pkg::magic_number;
            else
                shift_q <= {status_byte, 8'h00};   // status sits in the top byte
        end
        else if (tx_phase)
            shift_q <= {shift_q[11:0], 4'h0};

        if (tx_phase)
            qspi_out <= shift_q[15:12];   // high nibble first
    end

    always_ff @(posedge sclk or negedge rst_n)
    begin
        if (!rst_n)
            qspi_oe <= 1'b0;
        else
            qspi_oe <= tx_phase;
    end

endmodule

//--- design/spi_gpu_top.sv
`timescale 1ns/100ps

module spi_gpu_top (
    input  logic                     sclk,
    input  logic                     rst_n,
    input  logic                     cs,        // high means deselected
    input  spi_gpu_pkg::nibble_t     qspi_in,
    input  logic                     hblank,
    input  logic                     vblank,
    output spi_gpu_pkg::nibble_t     qspi_out,
    output logic                     qspi_oe,
    output spi_gpu_pkg::pixel_addr_t fb_addr,
    output spi_gpu_pkg::byte_t       fb_data,
    output logic                     fb_wren
);

    logic                       addr_phase;
    logic                       pixel_phase;
    logic                       resp_load;
    logic                       tx_phase;
    logic                       output_enabled;
    spi_gpu_pkg::response_sel_t resp_sel;

    qspi_rx_if rx_bus ();

    qspi_frontend u_frontend (
        .sclk    (sclk),
        .rst_n   (rst_n),
        .cs      (cs),
        .qspi_in (qspi_in),
        .rx      (rx_bus.source)
    );

    command_sequencer u_sequencer (
        .sclk           (sclk),
        .rst_n          (rst_n),
        .rx             (rx_bus.sequencer),
        .addr_phase     (addr_phase),
        .pixel_phase    (pixel_phase),
        .resp_load      (resp_load),
        .tx_phase       (tx_phase),
        .resp_sel       (resp_sel),
        .output_enabled (output_enabled)
    );

    pixel_writer u_pixel_writer (
        .sclk        (sclk),
        .rst_n       (rst_n),
        .rx          (rx_bus.writer),
        .addr_phase  (addr_phase),
        .pixel_phase (pixel_phase),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .fb_wren     (fb_wren)
    );

    response_shifter u_response_shifter (
        .sclk           (sclk),
        .rst_n          (rst_n),
        .hblank         (hblank),
        .vblank         (vblank),
        .resp_load      (resp_load),
        .tx_phase       (tx_phase),
        .resp_sel       (resp_sel),
        .output_enabled (output_enabled),
        .qspi_out       (qspi_out),
        .qspi_oe        (qspi_oe)
    );

endmodule

//--- dv/tb_spi_gpu.sv
`timescale 1ns/100ps

module tb_spi_gpu;

    localparam int          clk_period    = 100;
    localparam int          wait_limit    = 8;      // cycles allowed for late outputs
    localparam int          drain_cycles  = wait_limit + 8;
    localparam int          budget_margin = 64;
    localparam int          bogus_nibbles = spi_gpu_pkg::addr_nibbles + 4;  // room for a stray write
    localparam logic [15:0] lfsr_seed     = 16'd17895;

    logic                     sclk;
    logic                     rst_n;
    logic                     cs;
    spi_gpu_pkg::nibble_t     qspi_in;
    logic                     hblank;
    logic                     vblank;
    spi_gpu_pkg::nibble_t     qspi_out;
    logic                     qspi_oe;
    spi_gpu_pkg::pixel_addr_t fb_addr;
    spi_gpu_pkg::byte_t       fb_data;
    logic                     fb_wren;

    logic [15:0] lfsr_state;
    int          value_errors;
    int          count_errors;
    int          budget_cycles;

    // transaction lines from the data file
    string line_kind[$];
    int    line_cmd[$];
    int    line_hb[$];
    int    line_vb[$];
    int    line_value[$];
    int    line_count[$];

    spi_gpu_pkg::nibble_t     exp_nib[$];
    spi_gpu_pkg::nibble_t     got_nib[$];
    spi_gpu_pkg::pixel_addr_t exp_addr[$];
    spi_gpu_pkg::pixel_addr_t got_addr[$];
    spi_gpu_pkg::byte_t       exp_data[$];
    spi_gpu_pkg::byte_t       got_data[$];

    spi_gpu_top dut (
        .sclk     (sclk),
        .rst_n    (rst_n),
        .cs       (cs),
        .qspi_in  (qspi_in),
        .hblank   (hblank),
        .vblank   (vblank),
        .qspi_out (qspi_out),
        .qspi_oe  (qspi_oe),
        .fb_addr  (fb_addr),
        .fb_data  (fb_data),
        .fb_wren  (fb_wren)
    );

    initial sclk = 1'b0;

    always #(clk_period / 2) sclk = ~sclk;

    // outputs are stable at the falling edge
    always @(negedge sclk)
    begin
        if (qspi_oe)
            got_nib.push_back(qspi_out);
        if (fb_wren)
        begin
            got_addr.push_back(fb_addr);
            got_data.push_back(fb_data);
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[6:0], lfsr_state[0]};
        end
    endtask

    function automatic int line_cycles(input int idx);
        if (line_kind[idx] == "write")
            return 8 + 2 * line_count[idx];     // command, address, two nibbles per pixel
        if (line_kind[idx] == "bogus")
            return 2 + bogus_nibbles;
        return 6 + line_count[idx];
    endfunction

    task automatic send_nibble(input logic [3:0] n);
        @(posedge sclk);
        cs      <= 1'b0;
        qspi_in <= n;
    endtask

    task automatic compare_outputs();
        assert (got_nib.size() == exp_nib.size())
        else
        begin
            count_errors++;
            $display("expected %0d response nibbles but got %0d before %0t ns",
                     exp_nib.size(), got_nib.size(), $time);
        end
        assert (got_addr.size() == exp_addr.size())
        else
        begin
            count_errors++;
            $display("expected %0d framebuffer writes but got %0d before %0t ns",
                     exp_addr.size(), got_addr.size(), $time);
        end
        for (int i = 0; i < got_nib.size() && i < exp_nib.size(); i++)
            assert (got_nib[i] == exp_nib[i])
            else
            begin
                value_errors++;
                $display("[FAIL] %0t ns: response nibble %0d is %h, expected %h",
                         $time, i, got_nib[i], exp_nib[i]);
            end
        for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++)
            assert (got_addr[i] == exp_addr[i] && got_data[i] == exp_data[i])
            else
            begin
                value_errors++;
                $display("[FAIL] %0t ns: write %0d went to %0d with %h, expected %0d with %h",
                         $time, i, got_addr[i], got_data[i], exp_addr[i], exp_data[i]);
            end
        got_nib.delete();
        exp_nib.delete();
        got_addr.delete();
        exp_addr.delete();
        got_data.delete();
        exp_data.delete();
    endtask

    task automatic finish_transaction();
        int         waited;
        logic [7:0] gap;
        waited = 0;
        @(posedge sclk);
        cs <= 1'b1;
        while ((got_nib.size() < exp_nib.size() || got_addr.size() < exp_addr.size())
               && waited < wait_limit)
        begin
            @(posedge sclk);
            waited++;
        end
        repeat (2) @(posedge sclk);   // deselect reaches idle within two cycles
        compare_outputs();
        @(negedge sclk);
        assert (qspi_oe == 1'b0)
        else
        begin
            value_errors++;
            $display("[FAIL] %0t ns: qspi_oe still high after deselect", $time);
        end
        draw_bits(2, gap);
        repeat (int'(gap)) @(posedge sclk);
    endtask

    task automatic run_line(input int idx);
        logic [7:0]               cmd;
        logic [23:0]              start;
        logic [7:0]               pixel;
        spi_gpu_pkg::pixel_addr_t addr;
        int                       count;
        int                       extra;
        cmd   = 8'(line_cmd[idx]);
        count = line_count[idx];
        extra = 2;                    // stay selected a little past the response
        @(posedge sclk);
        hblank  <= (line_hb[idx] != 0);
        vblank  <= (line_vb[idx] != 0);
        cs      <= 1'b0;
        qspi_in <= cmd[7:4];
        send_nibble(cmd[3:0]);
        if (line_kind[idx] == "write")
        begin
            start = 24'(line_value[idx]);
            addr  = start[16:0];      // only the low 17 bits index the frame
            for (int i = 5; i >= 0; i--)
                send_nibble(start[4 * i +: 4]);
            for (int i = 0; i < count; i++)
            begin
                draw_bits(8, pixel);
                exp_addr.push_back(addr);
                exp_data.push_back(pixel);
                addr = spi_gpu_pkg::pixel_addr_t'((int'(addr) + 1) % spi_gpu_pkg::fb_pixels);
                send_nibble(pixel[7:4]);
                send_nibble(pixel[3:0]);
            end
        end
        else if (line_kind[idx] == "status" || line_kind[idx] == "magic" ||
                 line_kind[idx] == "abort")
        begin
            for (int i = count - 1; i >= 0; i--)
                exp_nib.push_back(4'(line_value[idx] >> (4 * i)));
            if (line_kind[idx] == "abort")
                extra = 0;            // chip select rises mid-response
            repeat (spi_gpu_pkg::dummy_cycles + count + extra) send_nibble(4'h0);
        end
        else if (line_kind[idx] == "bogus")
            repeat (bogus_nibbles) send_nibble(4'h0);
        else
            repeat (extra) send_nibble(4'h0);
        finish_transaction();
    endtask

    initial
    begin
        int    fd;
        int    budget;
        int    cmd;
        int    hb;
        int    vb;
        int    value;
        int    count;
        string text;
        string kind;
        cs            = 1'b1;
        qspi_in       = '0;
        hblank        = 1'b0;
        vblank        = 1'b0;
        rst_n         = 1'b0;
        value_errors  = 0;
        count_errors  = 0;
        budget_cycles = 0;
        lfsr_state    = lfsr_seed;
        fd = $fopen("dv/spi_gpu_testdata.txt", "r");
        if (fd == 0)
        begin
            count_errors++;
            $display("could not open dv/spi_gpu_testdata.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() > 1 && text[0] != "#" &&
                    $sscanf(text, "%s %h %d %d %h %d", kind, cmd, hb, vb, value, count) == 6)
                begin
                    line_kind.push_back(kind);
                    line_cmd.push_back(cmd);
                    line_hb.push_back(hb);
                    line_vb.push_back(vb);
                    line_value.push_back(value);
                    line_count.push_back(count);
                end
            end
            $fclose(fd);
        end
        budget = budget_margin + 4;
        foreach (line_kind[i])
            budget += line_cycles(i) + drain_cycles;
        budget_cycles = budget;

        repeat (4) @(posedge sclk);
        rst_n <= 1'b1;
        foreach (line_kind[i])
            run_line(i);

        $display("errors: %0d value, %0d count", value_errors, count_errors);
        if (value_errors == 0 && count_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin
        wait (budget_cycles > 0);
        #(budget_cycles * clk_period);
        $display("watchdog: run did not finish within %0d cycles", budget_cycles);
        $display("errors: %0d value, %0d count", value_errors, count_errors);
        $display("sim failed");
        $finish;
    end

endmodule

//--- compile.f
design/spi_gpu_pkg.sv
design/qspi_rx_if.sv
design/qspi_frontend.sv
design/command_sequencer.sv
design/pixel_writer.sv
design/response_shifter.sv
design/spi_gpu_top.sv
dv/tb_spi_gpu.sv

//--- Makefile
# Verilator build and run for the quad-SPI graphics slave

VERILATOR ?= verilator
TOP       ?= tb_spi_gpu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation reads its data file relative to the project root
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/spi_gpu_testdata.txt
# kind cmd hblank vblank value count
# write: value is the start address, count the pixel bytes; reads: value is the response
magic   60 0 0 A5C3   4
status  40 1 0 B4     2
enable  01 0 0 0      0
status  40 0 1 B3     2
write   82 0 0 000100 8
bogus   8F 0 0 0      0
status  40 1 1 B7     2
disable 00 0 0 0      0
status  40 0 0 B0     2
bogus   3C 0 0 0      0
status  40 1 1 B6     2
write   82 0 0 012BFE 4
abort   60 0 0 A5     2
magic   60 0 0 A5C3   4
abort   60 1 0 A      1
status  40 1 0 B4     2
write   82 0 0 F00010 6
enable  01 0 0 0      0
status  40 0 0 B1     2
write   82 0 0 012BFF 3
write   82 0 0 000000 20
magic   60 1 1 A5C3   4
